//--- verilog.f
verilog/id_pkg.sv
verilog/id_inst_latch.sv
verilog/id_decoder.sv
verilog/id_regfile.sv
verilog/id_forward.sv
verilog/id_branch.sv
verilog/id_stage.sv
dv/id_stage_properties.sv
dv/id_stage_tb.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench, exit status is the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module id_stage_tb -f verilog.f
./obj_dir/Vid_stage_tb

//--- dv/id_stage_tb.sv
`default_nettype none

module id_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import id_pkg::*;

    // expected one-hot controls, msb first as in the structs
    localparam logic [11:0] alu_add = 12'h800;
    localparam logic [11:0] alu_or  = 12'h020;
    localparam logic [11:0] alu_sll = 12'h008;
    localparam logic [11:0] alu_lui = 12'h001;
    localparam logic [2:0]  s1_none = 3'b000;
    localparam logic [2:0]  s1_rs   = 3'b001;
    localparam logic [2:0]  s1_sa   = 3'b100;
    localparam logic [3:0]  s2_rt   = 4'b0001;
    localparam logic [3:0]  s2_simm = 4'b0010;
    localparam logic [3:0]  s2_zimm = 4'b1000;
    localparam rf_write_t   no_wr   = '0;

    logic        clk;
    logic        rst;
    stall_t      stall;
    fetch_t      fetch;
    logic [31:0] inst_rdata = '0;
    logic        ex_load;
    rf_write_t   ex_wr;
    rf_write_t   mem_wr;
    rf_write_t   wb_wr;
    id_to_ex_t   to_ex;
    br_t         br;
    logic        stall_req;

    logic [31:0] imem [256];   // word index pc[9:2]
    logic [31:0] model [32];   // what the file should hold

    id_stage i_id_stage (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) inst_rdata <= imem[fetch.pc[9:2]];   // word one cycle after fetch

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [4:0] rs, rt, rd, sa,
                                          input logic [5:0] fn);
        return {op_special, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic rf_write_t make_wr(input logic [4:0] a, input logic [31:0] d);
        return '{we: 1'b1, waddr: a, wdata: d};
    endfunction

    function automatic logic [31:0] br_dest(input logic [31:0] pc, input logic [15:0] off);
        return pc + 32'd4 + 32'($signed(off)) * 32'd4;   // word offset from delay slot
    endfunction

    function automatic logic [31:0] jump_dest(input logic [31:0] pc, input logic [25:0] idx);
        return ((pc + 32'd4) & 32'hf000_0000) | {4'd0, idx, 2'b00};
    endfunction

    task automatic write_reg(input logic [4:0] a, input logic [31:0] d);
        @(posedge clk);
        wb_wr <= make_wr(a, d);
        @(posedge clk);
        wb_wr <= '0;
        if (a != 5'd0) model[a] = d;
    endtask

    task automatic wait_decode(input string name, input logic [31:0] pc);
        int n;
        n = 0;
        @(negedge clk);
        while (to_ex.pc !== pc) begin
            n++;
            if (n > 4) begin
                $display("timeout: %s never reached the decode slot", name);
                abort_run();
            end else begin
                @(negedge clk);
            end
        end
    endtask

    // one instruction through the latch, bypass levels arrive with it
    task automatic present(input string name, input logic [31:0] pc, input logic [31:0] word,
                           input rf_write_t ex, input rf_write_t mem, input rf_write_t wb,
                           input logic load);
        imem[pc[9:2]] = word;
        @(posedge clk);
        fetch   <= '{valid: 1'b1, pc: pc};
        ex_wr   <= '0;
        mem_wr  <= '0;
        wb_wr   <= '0;
        ex_load <= 1'b0;
        @(posedge clk);
        fetch   <= '0;
        ex_wr   <= ex;
        mem_wr  <= mem;
        wb_wr   <= wb;
        ex_load <= load;
        if (wb.we && wb.waddr != 5'd0) model[wb.waddr] = wb.wdata;   // lands next edge
        wait_decode(name, pc);
    endtask

    task automatic check_quiet(input string name);
        check({name, " rf_we/mem_en/mem_we/taken"}, 32'd0,
              {28'd0, to_ex.rf_we, to_ex.mem_en, to_ex.mem_we, br.taken});
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_quiet("reset");
    endtask

    task automatic test_bubble();
        imem[8'h20] = enc_j(op_jal, 26'h40);
        @(posedge clk);
        fetch <= '{valid: 1'b1, pc: 32'h80};
        @(posedge clk);                              // jal enters decode
        stall <= '{ex_stop: 1'b0, id_stop: 1'b1};
        @(negedge clk);
        check("bubble before rf_we", 32'd1, 32'(to_ex.rf_we));
        @(posedge clk);                              // bubble replaces the jal
        stall <= '0;
        @(negedge clk);
        check_quiet("bubble");
        @(posedge clk);                              // jal loads again
        fetch <= '0;
        @(negedge clk);
        check("bubble release rf_we", 32'd1, 32'(to_ex.rf_we));
    endtask

    task automatic test_hold();
        logic [31:0] wa;
        logic [31:0] wb;
        wa = enc_r(5'd1, 5'd2, 5'd3, 5'd0, fn_addu);
        wb = enc_i(op_ori, 5'd1, 5'd2, 16'h5555);
        imem[8'h80] = wa;
        imem[8'h81] = wb;
        @(posedge clk);
        fetch <= '{valid: 1'b1, pc: 32'h200};
        @(posedge clk);
        fetch <= '{valid: 1'b1, pc: 32'h204};        // imem moves on
        stall <= '{ex_stop: 1'b1, id_stop: 1'b1};
        wait_decode("hold", 32'h200);
        check("hold first", wa, to_ex.inst);
        @(negedge clk);
        check("hold imem moved", wb, inst_rdata);
        check("hold buffered", wa, to_ex.inst);
        @(negedge clk);
        check("hold still", wa, to_ex.inst);
        @(posedge clk);
        stall <= '0;
        @(posedge clk);                              // id released, B loads
        fetch <= '0;
        @(negedge clk);
        check("hold release pc", 32'h204, to_ex.pc);
        check("hold release inst", wb, to_ex.inst);
    endtask

    task automatic alu_case(input string name, input logic [31:0] pc, input logic [31:0] word,
                            input logic [11:0] alu, input logic [2:0] s1, input logic [3:0] s2,
                            input logic [3:0] flags, input logic [4:0] waddr,
                            input logic [31:0] exp1, input logic [31:0] exp2);
        present(name, pc, word, no_wr, no_wr, no_wr, 1'b0);
        check({name, " alu_op"}, 32'(alu), 32'(to_ex.alu_op));
        check({name, " src1_sel"}, 32'(s1), 32'(to_ex.src1_sel));
        check({name, " src2_sel"}, 32'(s2), 32'(to_ex.src2_sel));
        check({name, " mem_en/mem_we/rf_we/from_mem"}, 32'(flags),
              {28'd0, to_ex.mem_en, to_ex.mem_we, to_ex.rf_we, to_ex.rf_from_mem});
        check({name, " rf_waddr"}, 32'(waddr), 32'(to_ex.rf_waddr));
        check({name, " opnd1"}, exp1, to_ex.opnd1);
        check({name, " opnd2"}, exp2, to_ex.opnd2);
    endtask

    task automatic test_alu();
        for (int i = 1; i < 32; i++) write_reg(5'(i), $urandom());
        alu_case("addu", 32'h300, enc_r(5'd4, 5'd5, 5'd3, 5'd0, fn_addu),
                 alu_add, s1_rs, s2_rt, 4'b0010, 5'd3, model[4], model[5]);
        alu_case("ori", 32'h304, enc_i(op_ori, 5'd6, 5'd7, 16'h1234),
                 alu_or, s1_rs, s2_zimm, 4'b0010, 5'd7, model[6], model[7]);
        alu_case("sll", 32'h308, enc_r(5'd0, 5'd8, 5'd9, 5'd5, fn_sll),
                 alu_sll, s1_sa, s2_rt, 4'b0010, 5'd9, 32'd0, model[8]);
        alu_case("lui", 32'h30c, enc_i(op_lui, 5'd0, 5'd10, 16'habcd),
                 alu_lui, s1_none, s2_simm, 4'b0010, 5'd10, 32'd0, model[10]);
        alu_case("lw", 32'h310, enc_i(op_lw, 5'd11, 5'd12, 16'h0008),
                 alu_add, s1_rs, s2_simm, 4'b1011, 5'd12, model[11], model[12]);
        alu_case("sw", 32'h314, enc_i(op_sw, 5'd13, 5'd14, 16'hfffc),
                 alu_add, s1_rs, s2_simm, 4'b1100, 5'd14, model[13], model[14]);
    endtask

    task automatic test_forward();
        logic [31:0] w;
        logic [31:0] d_ex;
        logic [31:0] d_mem;
        logic [31:0] d_wb;
        w     = enc_r(5'd5, 5'd6, 5'd3, 5'd0, fn_addu);
        d_ex  = $urandom();
        d_mem = $urandom();
        d_wb  = $urandom();
        present("fwd ex", 32'h340, w, make_wr(5'd5, d_ex), make_wr(5'd5, d_mem),
                make_wr(5'd5, d_wb), 1'b0);
        check("fwd ex", d_ex, to_ex.opnd1);
        check("fwd ex rt untouched", model[6], to_ex.opnd2);
        d_wb = $urandom();
        present("fwd mem", 32'h344, w, no_wr, make_wr(5'd5, d_mem), make_wr(5'd5, d_wb), 1'b0);
        check("fwd mem", d_mem, to_ex.opnd1);
        d_wb = $urandom();                           // differs from the file now
        present("fwd wb", 32'h348, w, no_wr, no_wr, make_wr(5'd5, d_wb), 1'b0);
        check("fwd wb", d_wb, to_ex.opnd1);
        present("fwd file", 32'h34c, w, no_wr, no_wr, no_wr, 1'b0);
        check("fwd file", model[5], to_ex.opnd1);
        present("fwd r0", 32'h350, enc_r(5'd0, 5'd0, 5'd3, 5'd0, fn_addu),
                make_wr(5'd0, d_ex), make_wr(5'd0, d_mem), make_wr(5'd0, d_wb), 1'b0);
        check("fwd r0 opnd1", 32'd0, to_ex.opnd1);
        check("fwd r0 opnd2", 32'd0, to_ex.opnd2);
    endtask

    task automatic br_case(input string name, input logic [31:0] pc, input logic [31:0] word,
                           input logic exp_taken, input logic [31:0] exp_target);
        present(name, pc, word, no_wr, no_wr, no_wr, 1'b0);
        check({name, " taken"}, 32'(exp_taken), 32'(br.taken));
        check({name, " target"}, exp_target, br.target);
    endtask

    task automatic test_branch();
        logic [31:0] pc;
        logic [4:0]  r;
        logic [31:0] v;
        write_reg(5'd8, 32'hffff_fffb);              // -5
        write_reg(5'd9, 32'd0);
        write_reg(5'd10, 32'd7);
        write_reg(5'd11, 32'd7);
        write_reg(5'd12, 32'h0040_0100);             // jr destination
        br_case("beq eq", 32'h380, enc_i(op_beq, 5'd10, 5'd11, 16'h0010), 1'b1,
                br_dest(32'h380, 16'h0010));
        br_case("beq ne", 32'h384, enc_i(op_beq, 5'd10, 5'd8, 16'hfff0), 1'b0,
                br_dest(32'h384, 16'hfff0));
        br_case("bne eq", 32'h388, enc_i(op_bne, 5'd10, 5'd11, 16'h0020), 1'b0,
                br_dest(32'h388, 16'h0020));
        br_case("bne ne", 32'h38c, enc_i(op_bne, 5'd10, 5'd8, 16'hfffe), 1'b1,
                br_dest(32'h38c, 16'hfffe));
        pc = 32'h3a0;
        // negative, zero, positive operand in turn
        for (int k = 0; k < 3; k++) begin
            r = 5'd8 + 5'(k);
            v = model[r];
            br_case($sformatf("bgez r%0d", r), pc, enc_i(op_regimm, r, rt_bgez, 16'h0008),
                    $signed(v) >= 0, br_dest(pc, 16'h0008));
            pc += 32'd4;
            br_case($sformatf("bgtz r%0d", r), pc, enc_i(op_bgtz, r, 5'd0, 16'hff00),
                    $signed(v) > 0, br_dest(pc, 16'hff00));
            pc += 32'd4;
            br_case($sformatf("blez r%0d", r), pc, enc_i(op_blez, r, 5'd0, 16'h0100),
                    $signed(v) <= 0, br_dest(pc, 16'h0100));
            pc += 32'd4;
            br_case($sformatf("bltz r%0d", r), pc, enc_i(op_regimm, r, rt_bltz, 16'hfffc),
                    $signed(v) < 0, br_dest(pc, 16'hfffc));
            pc += 32'd4;
        end
        br_case("j", 32'h1000_03d0, enc_j(op_j, 26'h0123456), 1'b1,
                jump_dest(32'h1000_03d0, 26'h0123456));
        br_case("jal", 32'h1000_03d4, enc_j(op_jal, 26'h3abcdef), 1'b1,
                jump_dest(32'h1000_03d4, 26'h3abcdef));
        check("jal rf_waddr", 32'd31, 32'(to_ex.rf_waddr));
        check("jal rf_we", 32'd1, 32'(to_ex.rf_we));
        br_case("jr", 32'h3d8, enc_r(5'd12, 5'd0, 5'd0, 5'd0, fn_jr), 1'b1, model[12]);
        br_case("bltzal", 32'h3dc, enc_i(op_regimm, 5'd8, rt_bltzal, 16'h0004), 1'b1,
                br_dest(32'h3dc, 16'h0004));
        check("bltzal rf_waddr", 32'd31, 32'(to_ex.rf_waddr));
        check("bltzal rf_we", 32'd1, 32'(to_ex.rf_we));
    endtask

    task automatic stall_case(input string name, input logic [31:0] pc, input logic [4:0] rs,
                              input logic [4:0] rt, input logic load, input rf_write_t ex,
                              input logic exp);
        present(name, pc, enc_r(rs, rt, 5'd1, 5'd0, fn_addu), ex, no_wr, no_wr, load);
        check(name, 32'(exp), 32'(stall_req));
    endtask

    task automatic test_stall();
        logic [31:0] d;
        d = $urandom();
        stall_case("load-use rs", 32'h3e0, 5'd4, 5'd5, 1'b1, make_wr(5'd4, d), 1'b1);
        stall_case("load-use rt", 32'h3e4, 5'd4, 5'd5, 1'b1, make_wr(5'd5, d), 1'b1);
        stall_case("load other reg", 32'h3e8, 5'd4, 5'd5, 1'b1, make_wr(5'd6, d), 1'b0);
        stall_case("no load", 32'h3ec, 5'd4, 5'd5, 1'b0, make_wr(5'd4, d), 1'b0);
        stall_case("load we low", 32'h3f0, 5'd4, 5'd5, 1'b1,
                   '{we: 1'b0, waddr: 5'd4, wdata: d}, 1'b0);
        stall_case("load r0", 32'h3f4, 5'd0, 5'd5, 1'b1, make_wr(5'd0, d), 1'b0);
    endtask

    initial begin
        int seed_val;
        seed_val = $urandom(32'h02c6ea42);
        rst     = 1'b1;
        stall   = '0;
        fetch   = '0;
        ex_load = 1'b0;
        ex_wr   = '0;
        mem_wr  = '0;
        wb_wr   = '0;
        for (int i = 0; i < 256; i++) imem[8'(i)] = {24'hfc0000, 8'(i)};   // opcode 3f, no-op
        for (int i = 0; i < 32; i++) model[5'(i)] = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_bubble();
        test_hold();
        test_alu();
        test_forward();
        test_branch();
        test_stall();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/id_stage_properties.sv
`default_nettype none

module id_stage_properties (
    input logic clk,
    input logic rst,
    input logic cur_valid,
    input logic rf_we,
    input logic mem_en,
    input logic br_taken,
    input logic stall_req,
    input logic ex_load
);
    timeunit 1ns;
    timeprecision 1ps;

    // empty slot sends nothing downstream
    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        !cur_valid |-> !rf_we && !mem_en && !br_taken)
        else $error("control raised with no valid instruction in decode");

    a_stall_needs_load: assert property (@(posedge clk) disable iff (rst)
        stall_req |-> ex_load)
        else $error("stall request without a load in ex");

    a_taken_needs_valid: assert property (@(posedge clk) disable iff (rst)
        br_taken |-> cur_valid)   // no redirect from a bubble
        else $error("branch taken from an empty decode slot");

endmodule

bind id_stage id_stage_properties i_id_stage_properties (
    .clk       (clk),
    .rst       (rst),
    .cur_valid (cur.valid),
    .rf_we     (to_ex.rf_we),
    .mem_en    (to_ex.mem_en),
    .br_taken  (br.taken),
    .stall_req (stall_req),
    .ex_load   (ex_load)
);

`default_nettype wire

//--- verilog/id_stage.sv
`default_nettype none

module id_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  id_pkg::stall_t          stall,
    input  id_pkg::fetch_t          fetch,
    input  logic [id_pkg::xlen-1:0] inst_rdata,   // imem word, one cycle after fetch
    input  logic                    ex_load,
    input  id_pkg::rf_write_t       ex_wr,
    input  id_pkg::rf_write_t       mem_wr,
    input  id_pkg::rf_write_t       wb_wr,
    output id_pkg::id_to_ex_t       to_ex,
    output id_pkg::br_t             br,
    output logic                    stall_req
);
    import id_pkg::*;

    fetch_t          cur;
    logic [xlen-1:0] inst;
    dec_t            dec;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    logic [xlen-1:0] opnd1;    // after bypass
    logic [xlen-1:0] opnd2;

    // only registered point of the stage
    id_inst_latch i_latch (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .fetch      (fetch),
        .inst_rdata (inst_rdata),
        .cur        (cur),
        .inst       (inst)
    );

    id_decoder i_decoder (
        .valid (cur.valid),
        .inst  (inst),
        .dec   (dec)
    );

    id_regfile i_regfile (
        .clk    (clk),
        .raddr1 (dec.rs),
        .raddr2 (dec.rt),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wr     (wb_wr)
    );

    id_forward i_forward (
        .rs        (dec.rs),
        .rt        (dec.rt),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .ex_wr     (ex_wr),
        .mem_wr    (mem_wr),
        .wb_wr     (wb_wr),
        .ex_load   (ex_load),
        .opnd1     (opnd1),
        .opnd2     (opnd2),
        .stall_req (stall_req)
    );

    // resolved here, so only the delay slot follows
    id_branch i_branch (
        .kind  (dec.br_kind),
        .pc    (cur.pc),
        .inst  (inst),
        .opnd1 (opnd1),
        .opnd2 (opnd2),
        .br    (br)
    );

    assign to_ex = '{
        pc:          cur.pc,
        inst:        inst,
        alu_op:      dec.alu_op,
        src1_sel:    dec.src1_sel,
        src2_sel:    dec.src2_sel,
        mem_en:      dec.mem_en,
        mem_we:      dec.mem_we,
        rf_we:       dec.rf_we,
        rf_waddr:    dec.rf_waddr,
        rf_from_mem: dec.rf_from_mem,
        opnd1:       opnd1,
        opnd2:       opnd2
    };

endmodule

`default_nettype wire

//--- verilog/id_branch.sv
`default_nettype none

module id_branch (
    input  id_pkg::br_kind_t        kind,
    input  logic [id_pkg::xlen-1:0] pc,
    input  logic [id_pkg::xlen-1:0] inst,
    input  logic [id_pkg::xlen-1:0] opnd1,
    input  logic [id_pkg::xlen-1:0] opnd2,
    output id_pkg::br_t             br
);
    import id_pkg::*;

    logic [xlen-1:0] pc_next;     // delay slot pc
    logic [xlen-1:0] br_offset;
    logic [xlen-1:0] br_target;
    logic [xlen-1:0] jmp_target;
    logic            eq, neg, zero;

    assign pc_next    = pc + xlen'(pc_step);
    assign br_offset  = {{14{inst[15]}}, inst[15:0], 2'b00};
    assign br_target  = pc_next + br_offset;
    assign jmp_target = {pc_next[31:28], inst[25:0], 2'b00};   // stays in the 256MB region

    assign eq   = opnd1 == opnd2;
    assign neg  = opnd1[xlen-1];
    assign zero = opnd1 == '0;

    always_comb begin
        br = '0;
        case (kind)
            br_beq:         br = '{taken: eq,             target: br_target};
            br_bne:         br = '{taken: !eq,            target: br_target};
            br_bgez:        br = '{taken: !neg,           target: br_target};
            br_bgtz:        br = '{taken: !neg && !zero,  target: br_target};
            br_blez:        br = '{taken: neg || zero,    target: br_target};
            br_bltz:        br = '{taken: neg,            target: br_target};
            br_jump_direct: br = '{taken: 1'b1,           target: jmp_target};
            br_jump_reg:    br = '{taken: 1'b1,           target: opnd1};
            default:        br = '0;   // not a branch
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/id_forward.sv
`default_nettype none

module id_forward (
    input  logic [id_pkg::reg_addr_w-1:0] rs,
    input  logic [id_pkg::reg_addr_w-1:0] rt,
    input  logic [id_pkg::xlen-1:0]       rdata1,
    input  logic [id_pkg::xlen-1:0]       rdata2,
    input  id_pkg::rf_write_t             ex_wr,
    input  id_pkg::rf_write_t             mem_wr,
    input  id_pkg::rf_write_t             wb_wr,
    input  logic                          ex_load,
    output logic [id_pkg::xlen-1:0]       opnd1,
    output logic [id_pkg::xlen-1:0]       opnd2,
    output logic                          stall_req
);
    import id_pkg::*;

    // r0 writes are dropped downstream, so they never match
    function automatic logic hit(input rf_write_t w, input logic [reg_addr_w-1:0] addr);
        return w.we && addr != '0 && w.waddr == addr;
    endfunction

    // youngest result wins
    function automatic logic [xlen-1:0] pick(input logic [reg_addr_w-1:0] addr,
                                             input logic [xlen-1:0]       file_val,
                                             input rf_write_t             e,
                                             input rf_write_t             m,
                                             input rf_write_t             w);
        if (hit(e, addr)) return e.wdata;
        if (hit(m, addr)) return m.wdata;
        if (hit(w, addr)) return w.wdata;   // file write lands next edge
        return file_val;
    endfunction

    assign opnd1 = pick(rs, rdata1, ex_wr, mem_wr, wb_wr);
    assign opnd2 = pick(rt, rdata2, ex_wr, mem_wr, wb_wr);

    // ex has only an address, the loaded data is a cycle away
    assign stall_req = ex_load && (hit(ex_wr, rs) || hit(ex_wr, rt));

endmodule

`default_nettype wire

//--- verilog/id_regfile.sv
`default_nettype none

module id_regfile (
    input  logic                          clk,
    input  logic [id_pkg::reg_addr_w-1:0] raddr1,
    input  logic [id_pkg::reg_addr_w-1:0] raddr2,
    output logic [id_pkg::xlen-1:0]       rdata1,
    output logic [id_pkg::xlen-1:0]       rdata2,
    input  id_pkg::rf_write_t             wr
);
    import id_pkg::*;

    logic [xlen-1:0] regs [num_regs];

    // wb port only, value shows next cycle
    always_ff @(posedge clk) begin
        if (wr.we && wr.waddr != '0) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // r0 hardwired, never read from the array
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- verilog/id_decoder.sv
`default_nettype none

module id_decoder (
    input  logic                    valid,
    input  logic [id_pkg::xlen-1:0] inst,
    output id_pkg::dec_t            dec
);
    import id_pkg::*;

    logic [5:0]            opcode;
    logic [5:0]            fn;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;

    logic special, regimm;
    logic r_alu, r_shift_v, r_shift_i, rtype;
    logic imm_s, imm_z, is_lui, is_lw, is_sw;
    logic is_j, is_jal, is_jr, is_jalr;
    logic is_beq, is_bne, is_blez, is_bgtz;
    logic is_bltz, is_bgez, is_bltzal, is_bgezal;
    logic link;

    assign opcode = inst[31:26];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign fn     = inst[5:0];

    // every flag below carries valid, so bubbles decode to all-zero
    assign special = valid && opcode == op_special;
    assign regimm  = valid && opcode == op_regimm;

    assign r_alu = special && (fn inside {fn_add, fn_addu, fn_sub, fn_subu, fn_slt,
                                          fn_sltu, fn_and, fn_or, fn_xor, fn_nor});
    assign r_shift_v = special && (fn inside {fn_sllv, fn_srlv, fn_srav});  // amount in rs
    assign r_shift_i = special && (fn inside {fn_sll, fn_srl, fn_sra});     // amount in sa
    assign rtype     = r_alu || r_shift_v || r_shift_i;

    assign imm_s  = valid && (opcode inside {op_addi, op_addiu, op_slti, op_sltiu});
    assign imm_z  = valid && (opcode inside {op_andi, op_ori, op_xori});
    assign is_lui = valid && opcode == op_lui;
    assign is_lw  = valid && opcode == op_lw;
    assign is_sw  = valid && opcode == op_sw;

    assign is_j    = valid && opcode == op_j;
    assign is_jal  = valid && opcode == op_jal;
    assign is_jr   = special && fn == fn_jr;
    assign is_jalr = special && fn == fn_jalr;

    assign is_beq    = valid && opcode == op_beq;
    assign is_bne    = valid && opcode == op_bne;
    assign is_blez   = valid && opcode == op_blez && rt == '0;
    assign is_bgtz   = valid && opcode == op_bgtz && rt == '0;
    assign is_bltz   = regimm && rt == rt_bltz;
    assign is_bgez   = regimm && rt == rt_bgez;
    assign is_bltzal = regimm && rt == rt_bltzal;
    assign is_bgezal = regimm && rt == rt_bgezal;

    // alu computes pc + 8 for the return address
    assign link = is_jal || is_jalr || is_bltzal || is_bgezal;

    always_comb begin
        dec = '0;
        dec.rs = rs;
        dec.rt = rt;

        dec.alu_op.add    = (special && (fn inside {fn_add, fn_addu})) ||
                            (valid && (opcode inside {op_addi, op_addiu})) ||
                            is_lw || is_sw || link;    // address and link sums
        dec.alu_op.sub    = special && (fn inside {fn_sub, fn_subu});
        dec.alu_op.slt    = (special && fn == fn_slt) || (valid && opcode == op_slti);
        dec.alu_op.sltu   = (special && fn == fn_sltu) || (valid && opcode == op_sltiu);
        dec.alu_op.and_op = (special && fn == fn_and) || (valid && opcode == op_andi);
        dec.alu_op.nor_op = special && fn == fn_nor;
        dec.alu_op.or_op  = (special && fn == fn_or) || (valid && opcode == op_ori);
        dec.alu_op.xor_op = (special && fn == fn_xor) || (valid && opcode == op_xori);
        dec.alu_op.sll    = special && (fn inside {fn_sll, fn_sllv});
        dec.alu_op.srl    = special && (fn inside {fn_srl, fn_srlv});
        dec.alu_op.sra    = special && (fn inside {fn_sra, fn_srav});
        dec.alu_op.lui    = is_lui;

        dec.src1_sel.rs = r_alu || r_shift_v || imm_s || imm_z || is_lw || is_sw;
        dec.src1_sel.pc = link;
        dec.src1_sel.sa = r_shift_i;

        dec.src2_sel.rt    = rtype;
        dec.src2_sel.simm  = imm_s || is_lui || is_lw || is_sw;
        dec.src2_sel.eight = link;
        dec.src2_sel.zimm  = imm_z;

        dec.mem_en      = is_lw || is_sw;
        dec.mem_we      = is_sw;
        dec.rf_from_mem = is_lw;
        dec.rf_we       = rtype || imm_s || imm_z || is_lui || is_lw || link;

        // jalr is r-type but always links through ra here
        if (link) begin
            dec.rf_waddr = reg_addr_w'(link_reg);
        end else if (rtype) begin
            dec.rf_waddr = rd;
        end else begin
            dec.rf_waddr = rt;
        end

        if (is_beq)                       dec.br_kind = br_beq;
        else if (is_bne)                  dec.br_kind = br_bne;
        else if (is_bgez || is_bgezal)    dec.br_kind = br_bgez;   // link set above
        else if (is_bgtz)                 dec.br_kind = br_bgtz;
        else if (is_blez)                 dec.br_kind = br_blez;
        else if (is_bltz || is_bltzal)    dec.br_kind = br_bltz;
        else if (is_j || is_jal)          dec.br_kind = br_jump_direct;
        else if (is_jr || is_jalr)        dec.br_kind = br_jump_reg;
    end

endmodule

`default_nettype wire

//--- verilog/id_inst_latch.sv
`default_nettype none

module id_inst_latch (
    input  logic                    clk,
    input  logic                    rst,
    input  id_pkg::stall_t          stall,
    input  id_pkg::fetch_t          fetch,
    input  logic [id_pkg::xlen-1:0] inst_rdata,
    output id_pkg::fetch_t          cur,
    output logic [id_pkg::xlen-1:0] inst
);
    import id_pkg::*;

    logic            held;       // buffer owns the word
    logic [xlen-1:0] inst_buf;
    logic            full_stop;

    assign full_stop = stall.id_stop && stall.ex_stop;

    always_ff @(posedge clk) begin
        if (rst) begin
            cur  <= '0;
            held <= 1'b0;
        end else if (stall.id_stop && !stall.ex_stop) begin
            cur  <= '0;            // bubble into ex
            held <= 1'b0;
        end else if (!stall.id_stop) begin
            cur  <= fetch;
            held <= 1'b0;
        end else if (!held) begin
            // first cycle of a full stall
            held <= 1'b1;
        end
    end

    // imem moves on during a stall, so keep the word it gave first
    always_ff @(posedge clk) begin
        if (full_stop && !held) begin
            inst_buf <= inst_rdata;
        end
    end

    always_comb begin
        if (!cur.valid) begin
            inst = '0;             // empty slot decodes as nothing
        end else if (held) begin
            inst = inst_buf;
        end else begin
            inst = inst_rdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/id_pkg.sv
`default_nettype none

package id_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam int link_reg   = 31;   // ra, gets pc + 8
    localparam int pc_step    = 4;

    // primary opcode, inst[31:26]
    localparam logic [5:0]
        op_special = 6'h00, op_regimm = 6'h01, op_j     = 6'h02, op_jal   = 6'h03,
        op_beq     = 6'h04, op_bne    = 6'h05, op_blez  = 6'h06, op_bgtz  = 6'h07,
        op_addi    = 6'h08, op_addiu  = 6'h09, op_slti  = 6'h0a, op_sltiu = 6'h0b,
        op_andi    = 6'h0c, op_ori    = 6'h0d, op_xori  = 6'h0e, op_lui   = 6'h0f,
        op_lw      = 6'h23, op_sw     = 6'h2b;

    // special function field, inst[5:0]
    localparam logic [5:0]
        fn_sll  = 6'h00, fn_srl  = 6'h02, fn_sra  = 6'h03, fn_sllv = 6'h04,
        fn_srlv = 6'h06, fn_srav = 6'h07, fn_jr   = 6'h08, fn_jalr = 6'h09,
        fn_add  = 6'h20, fn_addu = 6'h21, fn_sub  = 6'h22, fn_subu = 6'h23,
        fn_and  = 6'h24, fn_or   = 6'h25, fn_xor  = 6'h26, fn_nor  = 6'h27,
        fn_slt  = 6'h2a, fn_sltu = 6'h2b;

    // regimm branches live in the rt field
    localparam logic [4:0]
        rt_bltz = 5'h00, rt_bgez = 5'h01, rt_bltzal = 5'h10, rt_bgezal = 5'h11;

    typedef struct packed {
        logic ex_stop;
        logic id_stop;
    } stall_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
    } fetch_t;

    // result heading for the file, from ex, mem or wb
    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
    } rf_write_t;

    // one-hot, same bit order as the ex alu
    typedef struct packed {
        logic add;
        logic sub;
        logic slt;
        logic sltu;
        logic and_op;
        logic nor_op;
        logic or_op;
        logic xor_op;
        logic sll;
        logic srl;
        logic sra;
        logic lui;
    } alu_op_t;

    typedef struct packed {
        logic sa;
        logic pc;
        logic rs;
    } src1_sel_t;

    typedef struct packed {
        logic zimm;    // zero-extended imm
        logic eight;   // link offset
        logic simm;    // sign-extended imm
        logic rt;
    } src2_sel_t;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_bgez,
        br_bgtz,
        br_blez,
        br_bltz,
        br_jump_direct,
        br_jump_reg
    } br_kind_t;

    typedef struct packed {
        alu_op_t               alu_op;
        src1_sel_t             src1_sel;
        src2_sel_t             src2_sel;
        logic                  mem_en;
        logic                  mem_we;   // word store strobe
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
        logic                  rf_from_mem;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        br_kind_t              br_kind;
    } dec_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       inst;
        alu_op_t               alu_op;
        src1_sel_t             src1_sel;
        src2_sel_t             src2_sel;
        logic                  mem_en;
        logic                  mem_we;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
        logic                  rf_from_mem;
        logic [xlen-1:0]       opnd1;
        logic [xlen-1:0]       opnd2;
    } id_to_ex_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } br_t;

endpackage

`default_nettype wire
